// File: hdl/nasti_mem_pkg.sv
// nasti memory shared types

package nasti_mem_pkg;

   // response codes on b and r
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } resp_t;

   // write port FSM
   typedef enum logic [1:0] {
      // waiting for an aw burst
      wr_idle,
      // waiting for the next w beat
      wr_data,
      // beat held, bank requested
      wr_commit,
      // b_valid up until b_ready
      wr_resp
   } wr_state_t;

   // read port FSM
   typedef enum logic [1:0] {
      // waiting for an ar burst
      rd_idle,
      // bank requested for the current beat
      rd_fetch,
      // word comes back from the bank
      rd_wait,
      // r_valid up until r_ready
      rd_send
   } rd_state_t;

endpackage

// File: hdl/nasti_write_port.sv
// NASTI write port
`timescale 1ns/1ps

module nasti_write_port #(
   parameter int ID_WIDTH     = 4,
   parameter int ADDR_WIDTH   = 16,
   parameter int DATA_WIDTH   = 64,
   parameter int MEM_WORDS    = 1024,
   localparam int STRB_WIDTH  = DATA_WIDTH / 8,
   localparam int INDEX_WIDTH = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
   input  logic                   clk,
   input  logic                   rstn,
   // aw channel
   input  logic                   aw_valid,
   output logic                   aw_ready,
   input  logic [ID_WIDTH-1:0]    aw_id,
   input  logic [ADDR_WIDTH-1:0]  aw_addr,
   input  logic [7:0]             aw_len,
   // w channel
   input  logic                   w_valid,
   output logic                   w_ready,
   input  logic [DATA_WIDTH-1:0]  w_data,
   input  logic [STRB_WIDTH-1:0]  w_strb,
   input  logic                   w_last,
   // b channel
   output logic                   b_valid,
   input  logic                   b_ready,
   output logic [ID_WIDTH-1:0]    b_id,
   output nasti_mem_pkg::resp_t   b_resp,
   // bank side
   output logic                   wr_req,
   input  logic                   wr_gnt,
   output logic [INDEX_WIDTH-1:0] wr_index,
   output logic [DATA_WIDTH-1:0]  wr_data,
   output logic [STRB_WIDTH-1:0]  wr_strb
);

   localparam int BYTE_SHIFT = $clog2(STRB_WIDTH);
   localparam logic [ADDR_WIDTH:0] WORD_LIMIT = (ADDR_WIDTH + 1)'(MEM_WORDS);

   nasti_mem_pkg::wr_state_t state;
   logic                     err;
   logic                     last_q;
   logic [7:0]               beats_left;
   // one spare bit so a long burst near the top cannot wrap
   logic [ADDR_WIDTH:0]      cur_index;
   logic                     in_range;
   logic                     aw_fire;
   logic                     w_fire;
   logic                     beat_done;

   assign aw_fire   = aw_valid && aw_ready;
   assign w_fire    = w_valid && w_ready;
   assign in_range  = cur_index < WORD_LIMIT;
   assign wr_req    = (state == nasti_mem_pkg::wr_commit) && in_range;
   assign beat_done = (state == nasti_mem_pkg::wr_commit) && (wr_gnt || !in_range);
   assign wr_index  = cur_index[INDEX_WIDTH-1:0];
   assign b_resp    = err ? nasti_mem_pkg::resp_slverr : nasti_mem_pkg::resp_okay;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state    <= nasti_mem_pkg::wr_idle;
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         b_valid  <= 1'b0;
         err      <= 1'b0;
      end else begin
         case (state)
            nasti_mem_pkg::wr_idle: begin
               aw_ready <= !aw_fire;
               if (aw_fire) begin
                  w_ready <= 1'b1;
                  err     <= 1'b0;
                  state   <= nasti_mem_pkg::wr_data;
               end
            end
            nasti_mem_pkg::wr_data: begin
               if (w_fire) begin
                  w_ready <= 1'b0;
                  state   <= nasti_mem_pkg::wr_commit;
               end
            end
            nasti_mem_pkg::wr_commit: begin
               // out of range beats are dropped but still counted
               if (beat_done) begin
                  err <= err || !in_range;
                  if (last_q) begin
                     b_valid <= 1'b1;
                     state   <= nasti_mem_pkg::wr_resp;
                  end else begin
                     w_ready <= 1'b1;
                     state   <= nasti_mem_pkg::wr_data;
                  end
               end
            end
            nasti_mem_pkg::wr_resp: begin
               if (b_ready) begin
                  b_valid  <= 1'b0;
                  aw_ready <= 1'b1;
                  state    <= nasti_mem_pkg::wr_idle;
               end
            end
            default: state <= nasti_mem_pkg::wr_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (aw_fire) begin
         b_id       <= aw_id;
         cur_index  <= {1'b0, aw_addr} >> BYTE_SHIFT;
         beats_left <= aw_len;
      end
      // burst closes on w_last or when the aw_len count runs out
      if (w_fire) begin
         wr_data <= w_data;
         wr_strb <= w_strb;
         last_q  <= w_last || (beats_left == 8'd0);
      end
      if (beat_done) begin
         cur_index  <= cur_index + (ADDR_WIDTH + 1)'(1);
         beats_left <= beats_left - 8'd1;
      end
   end

endmodule

// File: hdl/nasti_read_port.sv
// NASTI read port
`timescale 1ns/1ps

module nasti_read_port #(
   parameter int ID_WIDTH     = 4,
   parameter int ADDR_WIDTH   = 16,
   parameter int DATA_WIDTH   = 64,
   parameter int MEM_WORDS    = 1024,
   localparam int STRB_WIDTH  = DATA_WIDTH / 8,
   localparam int INDEX_WIDTH = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
   input  logic                   clk,
   input  logic                   rstn,
   // ar channel
   input  logic                   ar_valid,
   output logic                   ar_ready,
   input  logic [ID_WIDTH-1:0]    ar_id,
   input  logic [ADDR_WIDTH-1:0]  ar_addr,
   input  logic [7:0]             ar_len,
   // r channel
   output logic                   r_valid,
   input  logic                   r_ready,
   output logic [ID_WIDTH-1:0]    r_id,
   output logic [DATA_WIDTH-1:0]  r_data,
   output nasti_mem_pkg::resp_t   r_resp,
   output logic                   r_last,
   // bank side
   output logic                   rd_req,
   input  logic                   rd_gnt,
   output logic [INDEX_WIDTH-1:0] rd_index,
   input  logic                   rd_rdata_valid,
   input  logic [DATA_WIDTH-1:0]  rd_rdata
);

   localparam int BYTE_SHIFT = $clog2(STRB_WIDTH);
   localparam logic [ADDR_WIDTH:0] WORD_LIMIT = (ADDR_WIDTH + 1)'(MEM_WORDS);

   nasti_mem_pkg::rd_state_t state;
   logic [7:0]               beats_left;
   logic [ADDR_WIDTH:0]      cur_index;
   logic                     in_range;
   logic                     ar_fire;
   logic                     r_fire;
   logic                     load_zero;
   logic                     load_word;

   assign ar_fire   = ar_valid && ar_ready;
   assign r_fire    = r_valid && r_ready;
   assign in_range  = cur_index < WORD_LIMIT;
   assign rd_req    = (state == nasti_mem_pkg::rd_fetch) && in_range;
   assign rd_index  = cur_index[INDEX_WIDTH-1:0];
   // out of range beats skip the bank
   assign load_zero = (state == nasti_mem_pkg::rd_fetch) && !in_range;
   assign load_word = (state == nasti_mem_pkg::rd_wait) && rd_rdata_valid;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state    <= nasti_mem_pkg::rd_idle;
         ar_ready <= 1'b0;
         r_valid  <= 1'b0;
      end else begin
         case (state)
            nasti_mem_pkg::rd_idle: begin
               ar_ready <= !ar_fire;
               if (ar_fire) begin
                  state <= nasti_mem_pkg::rd_fetch;
               end
            end
            nasti_mem_pkg::rd_fetch: begin
               if (load_zero) begin
                  r_valid <= 1'b1;
                  state   <= nasti_mem_pkg::rd_send;
               end else if (rd_gnt) begin
                  state <= nasti_mem_pkg::rd_wait;
               end
            end
            nasti_mem_pkg::rd_wait: begin
               if (load_word) begin
                  r_valid <= 1'b1;
                  state   <= nasti_mem_pkg::rd_send;
               end
            end
            nasti_mem_pkg::rd_send: begin
               if (r_ready) begin
                  r_valid <= 1'b0;
                  if (r_last) begin
                     ar_ready <= 1'b1;
                     state    <= nasti_mem_pkg::rd_idle;
                  end else begin
                     state <= nasti_mem_pkg::rd_fetch;
                  end
               end
            end
            default: state <= nasti_mem_pkg::rd_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire) begin
         r_id       <= ar_id;
         cur_index  <= {1'b0, ar_addr} >> BYTE_SHIFT;
         beats_left <= ar_len;
      end
      if (load_zero) begin
         r_data <= '0;
         r_resp <= nasti_mem_pkg::resp_slverr;
         r_last <= beats_left == 8'd0;
      end
      if (load_word) begin
         r_data <= rd_rdata;
         r_resp <= nasti_mem_pkg::resp_okay;
         r_last <= beats_left == 8'd0;
      end
      if (r_fire) begin
         cur_index  <= cur_index + (ADDR_WIDTH + 1)'(1);
         beats_left <= beats_left - 8'd1;
      end
   end

endmodule

// File: hdl/mem_bank.sv
// shared word storage bank
`timescale 1ns/1ps

module mem_bank #(
   parameter int DATA_WIDTH   = 64,
   parameter int MEM_WORDS    = 1024,
   localparam int STRB_WIDTH  = DATA_WIDTH / 8,
   localparam int INDEX_WIDTH = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
   input  logic                   clk,
   input  logic                   rstn,
   // write requester
   input  logic                   wr_req,
   output logic                   wr_gnt,
   input  logic [INDEX_WIDTH-1:0] wr_index,
   input  logic [DATA_WIDTH-1:0]  wr_data,
   input  logic [STRB_WIDTH-1:0]  wr_strb,
   // read requester
   input  logic                   rd_req,
   output logic                   rd_gnt,
   input  logic [INDEX_WIDTH-1:0] rd_index,
   output logic                   rd_rdata_valid,
   output logic [DATA_WIDTH-1:0]  rd_rdata
);

   logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

   // set when the last grant went to the read side
   logic last_rd;

   // round robin, a lone requester wins at once
   assign wr_gnt = wr_req && (!rd_req || last_rd);
   assign rd_gnt = rd_req && !wr_gnt;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         // write side goes first after reset
         last_rd <= 1'b1;
      end else if (wr_gnt || rd_gnt) begin
         last_rd <= rd_gnt;
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         rd_rdata_valid <= 1'b0;
      end else begin
         rd_rdata_valid <= rd_gnt;
      end
   end

   // one access per cycle, the arbiter never grants both
   always_ff @(posedge clk) begin
      if (wr_gnt) begin
         for (int b = 0; b < STRB_WIDTH; b++) begin
            if (wr_strb[b]) begin
               mem[wr_index][8*b +: 8] <= wr_data[8*b +: 8];
            end
         end
      end
      if (rd_gnt) begin
         rd_rdata <= mem[rd_index];
      end
   end

endmodule

// File: hdl/nasti_mem.sv
// NASTI on-chip memory slave
`timescale 1ns/1ps

module nasti_mem #(
   parameter int ID_WIDTH     = 4,
   parameter int ADDR_WIDTH   = 16,
   parameter int DATA_WIDTH   = 64,
   parameter int MEM_WORDS    = 1024,
   localparam int STRB_WIDTH  = DATA_WIDTH / 8,
   localparam int INDEX_WIDTH = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
   input  logic                  clk,
   input  logic                  rstn,
   // aw channel
   input  logic                  aw_valid,
   output logic                  aw_ready,
   input  logic [ID_WIDTH-1:0]   aw_id,
   input  logic [ADDR_WIDTH-1:0] aw_addr,
   input  logic [7:0]            aw_len,
   // w channel
   input  logic                  w_valid,
   output logic                  w_ready,
   input  logic [DATA_WIDTH-1:0] w_data,
   input  logic [STRB_WIDTH-1:0] w_strb,
   input  logic                  w_last,
   // b channel
   output logic                  b_valid,
   input  logic                  b_ready,
   output logic [ID_WIDTH-1:0]   b_id,
   output nasti_mem_pkg::resp_t  b_resp,
   // ar channel
   input  logic                  ar_valid,
   output logic                  ar_ready,
   input  logic [ID_WIDTH-1:0]   ar_id,
   input  logic [ADDR_WIDTH-1:0] ar_addr,
   input  logic [7:0]            ar_len,
   // r channel
   output logic                  r_valid,
   input  logic                  r_ready,
   output logic [ID_WIDTH-1:0]   r_id,
   output logic [DATA_WIDTH-1:0] r_data,
   output nasti_mem_pkg::resp_t  r_resp,
   output logic                  r_last
);

   // port to bank paths
   logic                   wr_req;
   logic                   wr_gnt;
   logic [INDEX_WIDTH-1:0] wr_index;
   logic [DATA_WIDTH-1:0]  wr_data;
   logic [STRB_WIDTH-1:0]  wr_strb;
   logic                   rd_req;
   logic                   rd_gnt;
   logic [INDEX_WIDTH-1:0] rd_index;
   logic                   rd_rdata_valid;
   logic [DATA_WIDTH-1:0]  rd_rdata;

   nasti_write_port #(
      .ID_WIDTH   (ID_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .DATA_WIDTH (DATA_WIDTH),
      .MEM_WORDS  (MEM_WORDS)
   ) u_wr_port (
      .clk, .rstn,
      .aw_valid, .aw_ready, .aw_id, .aw_addr, .aw_len,
      .w_valid, .w_ready, .w_data, .w_strb, .w_last,
      .b_valid, .b_ready, .b_id, .b_resp,
      .wr_req, .wr_gnt, .wr_index, .wr_data, .wr_strb
   );

   nasti_read_port #(
      .ID_WIDTH   (ID_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .DATA_WIDTH (DATA_WIDTH),
      .MEM_WORDS  (MEM_WORDS)
   ) u_rd_port (
      .clk, .rstn,
      .ar_valid, .ar_ready, .ar_id, .ar_addr, .ar_len,
      .r_valid, .r_ready, .r_id, .r_data, .r_resp, .r_last,
      .rd_req, .rd_gnt, .rd_index, .rd_rdata_valid, .rd_rdata
   );

   mem_bank #(
      .DATA_WIDTH (DATA_WIDTH),
      .MEM_WORDS  (MEM_WORDS)
   ) u_bank (
      .clk, .rstn,
      .wr_req, .wr_gnt, .wr_index, .wr_data, .wr_strb,
      .rd_req, .rd_gnt, .rd_index, .rd_rdata_valid, .rd_rdata
   );

endmodule

// File: tests/tb_nasti_mem.sv
// NASTI memory testbench
`timescale 1ns/1ps

module tb_nasti_mem;

   localparam int ID_W        = 4;
   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 64;
   localparam int STRB_W      = DATA_W / 8;
   localparam int MEM_WORDS   = 1024;
   localparam int SEQ_PAIRS   = 6;
   localparam int CONC_BURSTS = 10;
   // covers words 512 to 647 left by the write stream
   localparam int BACK_BURSTS = 17;
   // every burst counted at 8 beats
   localparam int PLANNED_BEATS  = 8 * (2 * SEQ_PAIRS + 3 + 2 * CONC_BURSTS + BACK_BURSTS);
   localparam int TIMEOUT_CYCLES = 40 * PLANNED_BEATS + 1000;

   logic                 clk;
   logic                 rstn;
   logic                 aw_valid;
   logic                 aw_ready;
   logic [ID_W-1:0]      aw_id;
   logic [ADDR_W-1:0]    aw_addr;
   logic [7:0]           aw_len;
   logic                 w_valid;
   logic                 w_ready;
   logic [DATA_W-1:0]    w_data;
   logic [STRB_W-1:0]    w_strb;
   logic                 w_last;
   logic                 b_valid;
   logic                 b_ready;
   logic [ID_W-1:0]      b_id;
   nasti_mem_pkg::resp_t b_resp;
   logic                 ar_valid;
   logic                 ar_ready;
   logic [ID_W-1:0]      ar_id;
   logic [ADDR_W-1:0]    ar_addr;
   logic [7:0]           ar_len;
   logic                 r_valid;
   logic                 r_ready;
   logic [ID_W-1:0]      r_id;
   logic [DATA_W-1:0]    r_data;
   nasti_mem_pkg::resp_t r_resp;
   logic                 r_last;

   logic [15:0]          lfsr;
   logic [DATA_W-1:0]    ref_mem [MEM_WORDS];
   // bytes that have been written at least once
   logic [STRB_W-1:0]    ref_known [MEM_WORDS];
   logic [ID_W-1:0]      b_exp_id [$];
   nasti_mem_pkg::resp_t b_exp_resp [$];
   int                   r_exp_idx [$];
   logic [ID_W-1:0]      r_exp_id [$];
   logic                 r_exp_last [$];
   logic [ID_W-1:0]      exp_id;
   nasti_mem_pkg::resp_t exp_resp;
   int                   exp_idx;
   logic                 exp_last;
   logic [DATA_W-1:0]    exp_mask;
   logic [63:0]          seq_rnd;
   logic [63:0]          wr_rnd;
   logic [63:0]          rd_rnd;
   logic [63:0]          bp_rnd;
   logic                 bp_on;
   int                   err_data;
   int                   err_resp;
   int                   err_proto;
   int                   cycles;

   nasti_mem u_dut (
      .clk, .rstn,
      .aw_valid, .aw_ready, .aw_id, .aw_addr, .aw_len,
      .w_valid, .w_ready, .w_data, .w_strb, .w_last,
      .b_valid, .b_ready, .b_id, .b_resp,
      .ar_valid, .ar_ready, .ar_id, .ar_addr, .ar_len,
      .r_valid, .r_ready, .r_id, .r_data, .r_resp, .r_last
   );

   always #10 clk = ~clk;

   // taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic void ref_write(input int idx, input logic [DATA_W-1:0] data,
                                     input logic [STRB_W-1:0] strb);
      if (idx < MEM_WORDS) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
               ref_mem[idx][8*b +: 8] = data[8*b +: 8];
               ref_known[idx][b] = 1'b1;
            end
         end
      end
   endfunction

   function automatic logic [DATA_W-1:0] ref_word(input int idx);
      return (idx < MEM_WORDS) ? ref_mem[idx] : '0;
   endfunction

   function automatic nasti_mem_pkg::resp_t ref_resp(input int idx);
      return (idx < MEM_WORDS) ? nasti_mem_pkg::resp_okay : nasti_mem_pkg::resp_slverr;
   endfunction

   function automatic logic [DATA_W-1:0] byte_mask(input int idx);
      logic [DATA_W-1:0] m;
      m = '1;
      if (idx < MEM_WORDS) begin
         for (int b = 0; b < STRB_W; b++) begin
            m[8*b +: 8] = {8{ref_known[idx][b]}};
         end
      end
      return m;
   endfunction

   task automatic check_low(input string name, input logic value);
      assert (value === 1'b0) else begin
         err_proto++;
         $display("ERR %s expected %h got %h", name, 1'b0, value);
      end
   endtask

   task automatic write_burst(input logic [ID_W-1:0] id, input int idx, input logic [7:0] len);
      logic [63:0]          r;
      nasti_mem_pkg::resp_t resp;
      resp = nasti_mem_pkg::resp_okay;
      for (int i = 0; i <= int'(len); i++) begin
         if (ref_resp(idx + i) == nasti_mem_pkg::resp_slverr) begin
            resp = nasti_mem_pkg::resp_slverr;
         end
      end
      b_exp_id.push_back(id);
      b_exp_resp.push_back(resp);
      @(posedge clk);
      #2;
      aw_valid = 1'b1;
      aw_id    = id;
      aw_addr  = ADDR_W'(idx * STRB_W);
      aw_len   = len;
      @(negedge clk);
      while (!aw_ready) @(negedge clk);
      @(posedge clk);
      #2;
      aw_valid = 1'b0;
      for (int i = 0; i <= int'(len); i++) begin
         r = rand_bits(DATA_W);
         w_data = r;
         r = rand_bits(STRB_W);
         w_strb  = r[STRB_W-1:0];
         w_last  = (i == int'(len));
         w_valid = 1'b1;
         ref_write(idx + i, w_data, w_strb);
         @(negedge clk);
         while (!w_ready) @(negedge clk);
         @(posedge clk);
         #2;
         w_valid = 1'b0;
      end
   endtask

   task automatic read_burst(input logic [ID_W-1:0] id, input int idx, input logic [7:0] len);
      for (int i = 0; i <= int'(len); i++) begin
         r_exp_idx.push_back(idx + i);
         r_exp_id.push_back(id);
         r_exp_last.push_back(i == int'(len));
      end
      @(posedge clk);
      #2;
      ar_valid = 1'b1;
      ar_id    = id;
      ar_addr  = ADDR_W'(idx * STRB_W);
      ar_len   = len;
      @(negedge clk);
      while (!ar_ready) @(negedge clk);
      @(posedge clk);
      #2;
      ar_valid = 1'b0;
   endtask

   task automatic wait_idle();
      while (b_exp_id.size() != 0 || r_exp_idx.size() != 0) @(negedge clk);
   endtask

   // b_ready and r_ready back-pressure
   always @(posedge clk) begin
      #2;
      if (bp_on) begin
         bp_rnd  = rand_bits(2);
         b_ready = bp_rnd[0];
         r_ready = bp_rnd[1];
      end else begin
         b_ready = 1'b1;
         r_ready = 1'b1;
      end
   end

   // compare every b and r transfer at the falling edge
   always @(negedge clk) begin
      if (rstn && b_valid && b_ready) begin
         assert (b_exp_id.size() > 0) else begin
            err_proto++;
            $display("b response arrived with no write burst outstanding");
         end
         if (b_exp_id.size() > 0) begin
            exp_id   = b_exp_id.pop_front();
            exp_resp = b_exp_resp.pop_front();
            assert (b_id == exp_id) else begin
               err_resp++;
               $display("ERR b_id expected %h got %h", exp_id, b_id);
            end
            assert (b_resp == exp_resp) else begin
               err_resp++;
               $display("ERR b_resp expected %h got %h", exp_resp, b_resp);
            end
         end
      end
      if (rstn && r_valid && r_ready) begin
         assert (r_exp_idx.size() > 0) else begin
            err_proto++;
            $display("r beat arrived with no read burst outstanding");
         end
         if (r_exp_idx.size() > 0) begin
            exp_idx  = r_exp_idx.pop_front();
            exp_id   = r_exp_id.pop_front();
            exp_last = r_exp_last.pop_front();
            exp_mask = byte_mask(exp_idx);
            assert ((r_data & exp_mask) == (ref_word(exp_idx) & exp_mask)) else begin
               err_data++;
               $display("ERR r_data word %0d expected %h got %h", exp_idx,
                        ref_word(exp_idx) & exp_mask, r_data & exp_mask);
            end
            assert (r_id == exp_id) else begin
               err_resp++;
               $display("ERR r_id expected %h got %h", exp_id, r_id);
            end
            assert (r_resp == ref_resp(exp_idx)) else begin
               err_resp++;
               $display("ERR r_resp expected %h got %h", ref_resp(exp_idx), r_resp);
            end
            assert (r_last == exp_last) else begin
               err_resp++;
               $display("ERR r_last expected %h got %h", exp_last, r_last);
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("timeout, bursts still open after %0d cycles", cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   initial begin
      clk = 1'b0;
      rstn = 1'b0;
      lfsr = 16'd21081;
      {aw_valid, aw_id, aw_addr, aw_len} = '0;
      {w_valid, w_data, w_strb, w_last} = '0;
      {ar_valid, ar_id, ar_addr, ar_len} = '0;
      b_ready = 1'b0;
      r_ready = 1'b0;
      bp_on = 1'b0;
      {err_data, err_resp, err_proto, cycles} = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         ref_known[i] = '0;
      end
      repeat (16) @(posedge clk);
      #2;
      rstn = 1'b1;
      @(negedge clk);
      check_low("b_valid", b_valid);
      check_low("r_valid", r_valid);
      check_low("aw_ready", aw_ready);
      check_low("w_ready", w_ready);
      check_low("ar_ready", ar_ready);
      // write then read back the same words
      for (int p = 0; p < SEQ_PAIRS; p++) begin
         seq_rnd = rand_bits(17);
         write_burst(seq_rnd[3:0], int'(seq_rnd[9:4]), {5'd0, seq_rnd[12:10]});
         wait_idle();
         read_burst(seq_rnd[16:13], int'(seq_rnd[9:4]), {5'd0, seq_rnd[12:10]});
         wait_idle();
      end
      // bursts across the top of the bank
      write_burst(4'h5, MEM_WORDS - 4, 8'd7);
      wait_idle();
      read_burst(4'h6, MEM_WORDS - 4, 8'd7);
      wait_idle();
      read_burst(4'h7, MEM_WORDS - 4, 8'd3);
      wait_idle();
      // writes high and reads low at the same time
      bp_on = 1'b1;
      fork
         for (int k = 0; k < CONC_BURSTS; k++) begin
            wr_rnd = rand_bits(14);
            write_burst(wr_rnd[3:0], 512 + int'(wr_rnd[10:4]), {5'd0, wr_rnd[13:11]});
         end
         for (int k = 0; k < CONC_BURSTS; k++) begin
            rd_rnd = rand_bits(13);
            read_burst(rd_rnd[3:0], int'(rd_rnd[9:4]), {5'd0, rd_rnd[12:10]});
         end
      join
      wait_idle();
      // read back what the write stream stored under contention
      for (int k = 0; k < BACK_BURSTS; k++) begin
         read_burst(ID_W'(k), 512 + 8 * k, 8'd7);
      end
      wait_idle();
      repeat (4) @(posedge clk);
      $display("errors: data %0d, response %0d, protocol %0d", err_data, err_resp, err_proto);
      if (err_data + err_resp + err_proto == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: nasti_mem.f
hdl/nasti_mem_pkg.sv
hdl/nasti_write_port.sv
hdl/nasti_read_port.sv
hdl/mem_bank.sv
hdl/nasti_mem.sv
tests/tb_nasti_mem.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_nasti_mem
FILELIST   := nasti_mem.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := SOME TESTS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
